// File: source/crossbar_config.svh
`ifndef CROSSBAR_CONFIG_SVH
`define CROSSBAR_CONFIG_SVH

// Trigger channel counts
// Same count on the input and output side of the matrix
`define TRIG_CHANNELS		12

// Source index wide enough for 12 inputs plus spare codes
`define TRIG_SEL_BITS		4

// Inputs with P/N swapped in PCB layout
// Bits 0, 2, 5 and 6
`define TRIG_POLARITY_MASK	12'h065

// Latching relays on the H-bridge drivers
`define RELAY_COUNT			4

// LED hold of about 100 ms at 250 MHz
`define LED_HOLD_DEFAULT	25000000

// Relay coil pulse of about 10 ms at 250 MHz
`define RELAY_PULSE_DEFAULT	2500000

`endif

// File: source/crossbar_pkg.sv
`default_nettype none

`include "crossbar_config.svh"

package crossbar_pkg;

	// Routing select for one output
	// Disabled entry holds the output low
	typedef struct packed {
		logic						en;
		logic[`TRIG_SEL_BITS-1:0]	src;
	} muxsel_t;

	// Select table write
	// Output index is source sized
	// Codes 12..15 are dropped
	typedef struct packed {
		logic						wr_en;
		logic[`TRIG_SEL_BITS-1:0]	out_idx;
		muxsel_t					sel;
	} sel_write_t;

	// Relay toggle request
	// dir=1 energizes the A side, dir=0 the B side
	typedef struct packed {
		logic								req;
		logic								dir;
		logic[$clog2(`RELAY_COUNT)-1:0]		channel;
	} relay_cmd_t;

endpackage

`default_nettype wire

// File: source/trigger_input_stage.sv
`default_nettype none

`include "crossbar_config.svh"

module trigger_input_stage(
	input wire							clk_250mhz,
	input wire							rst,

	// Post-buffer levels, not yet in the fabric clock domain
	input wire[`TRIG_CHANNELS-1:0]		trig_in,

	// Sampled and polarity corrected
	output logic[`TRIG_CHANNELS-1:0]	trig_fixed
);

	// Board swap correction
	// Only place the mask is applied
	logic[`TRIG_CHANNELS-1:0]	trig_unswapped;

	always_comb begin
		trig_unswapped = trig_in ^ `TRIG_POLARITY_MASK;
	end

	// Single capture stage into clk_250mhz
	// Inversion sits ahead of the flop so latency stays at one cycle
	always_ff @(posedge clk_250mhz) begin
		if(rst) begin
			trig_fixed	<= '0;
		end
		else begin
			trig_fixed	<= trig_unswapped;
		end
	end

endmodule

`default_nettype wire

// File: source/select_register_bank.sv
`default_nettype none

`include "crossbar_config.svh"

module select_register_bank(
	input wire											clk_250mhz,
	input wire											rst,

	// Write strobe from the register interface
	input wire crossbar_pkg::sel_write_t				sel_wr,

	// Routing table, one entry per output
	output crossbar_pkg::muxsel_t[`TRIG_CHANNELS-1:0]	muxsel
);

	// Per-output write enables
	logic[`TRIG_CHANNELS-1:0]	wr_hit;

	// Decode output index
	// Out of range indices hit nothing
	always_comb begin
		for(int i=0; i<`TRIG_CHANNELS; i++) begin
			wr_hit[i]	= sel_wr.wr_en && (sel_wr.out_idx == i);
		end
	end

	// Table storage
	always_ff @(posedge clk_250mhz) begin
		if(rst) begin
			// Everything disabled, outputs held low
			for(int i=0; i<`TRIG_CHANNELS; i++) begin
				muxsel[i].en	<= 1'b0;
				muxsel[i].src	<= '0;
			end
		end
		else begin
			for(int i=0; i<`TRIG_CHANNELS; i++) begin
				if(wr_hit[i])
					muxsel[i]	<= sel_wr.sel;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/crossbar_matrix.sv
`default_nettype none

`include "crossbar_config.svh"

module crossbar_matrix(
	input wire											clk_250mhz,
	input wire											rst,

	// Corrected trigger inputs
	input wire[`TRIG_CHANNELS-1:0]						trig_fixed,

	// Source select per output
	input wire crossbar_pkg::muxsel_t[`TRIG_CHANNELS-1:0]	muxsel,

	// Registered trigger outputs
	output logic[`TRIG_CHANNELS-1:0]					trig_out
);

	// Next output state from the selectors
	logic[`TRIG_CHANNELS-1:0]	route_next;

	// Twelve 12:1 muxes
	// Disabled outputs and spare source codes drive 0
	always_comb begin
		for(int i=0; i<`TRIG_CHANNELS; i++) begin
			route_next[i]	= 1'b0;

			if(muxsel[i].en && (muxsel[i].src < `TRIG_CHANNELS))
				route_next[i]	= trig_fixed[muxsel[i].src];
		end
	end

	// Output register
	// Keeps mux depth off the output pins
	always_ff @(posedge clk_250mhz) begin
		if(rst) begin
			trig_out	<= '0;
		end
		else begin
			trig_out	<= route_next;
		end
	end

endmodule

`default_nettype wire

// File: source/activity_stretcher.sv
`default_nettype none

module activity_stretcher #(
	parameter int width				= 12,
	parameter int led_hold_cycles	= 8
)(
	input wire				clk_250mhz,
	input wire				rst,

	// Trigger levels to monitor
	input wire[width-1:0]	activity,

	// Stretched indicators
	output logic[width-1:0]	led
);

	// Counter sized to hold the full reload value
	localparam int cnt_bits = $clog2(led_hold_cycles + 1);

	logic[cnt_bits-1:0]	hold_cnt[width];

	// One hold counter per bit
	always_ff @(posedge clk_250mhz) begin
		if(rst) begin
			for(int i=0; i<width; i++)
				hold_cnt[i]	<= '0;
		end
		else begin
			for(int i=0; i<width; i++) begin
				// Reload while active
				if(activity[i])
					hold_cnt[i]	<= cnt_bits'(led_hold_cycles);

				// Count down once idle
				else if(hold_cnt[i] != 0)
					hold_cnt[i]	<= hold_cnt[i] - 1'b1;
			end
		end
	end

	// Lit whenever the counter has time left
	always_comb begin
		for(int i=0; i<width; i++)
			led[i]	= (hold_cnt[i] != 0);
	end

endmodule

`default_nettype wire

// File: source/relay_pulse_driver.sv
`default_nettype none

`include "crossbar_config.svh"

module relay_pulse_driver #(
	parameter int relay_pulse_cycles	= 6
)(
	input wire								clk_250mhz,
	input wire								rst,

	// Toggle request
	input wire crossbar_pkg::relay_cmd_t	relay_cmd,

	// H-bridge drives, one side per relay
	output logic[`RELAY_COUNT-1:0]			relay_a,
	output logic[`RELAY_COUNT-1:0]			relay_b,

	// One cycle strobe after the coil drops
	output logic							relay_done
);

	localparam int cnt_bits = $clog2(relay_pulse_cycles + 1);

	typedef enum logic[1:0] {
		state_idle,
		state_pulse,
		state_done
	} state_t;

	state_t							state;
	logic[cnt_bits-1:0]				pulse_cnt;

	// Latched request fields
	logic							lat_dir;
	logic[$clog2(`RELAY_COUNT)-1:0]	lat_channel;

	//////////////////////////////
	// Control FSM

	always_ff @(posedge clk_250mhz) begin
		if(rst) begin
			state		<= state_idle;
			pulse_cnt	<= '0;
		end
		else begin
			case(state)

				// New requests only taken here
				state_idle: begin
					if(relay_cmd.req) begin
						state		<= state_pulse;
						pulse_cnt	<= cnt_bits'(relay_pulse_cycles - 1);
					end
				end

				// Coil energized, last cycle at count 0
				state_pulse: begin
					if(pulse_cnt == 0)
						state		<= state_done;
					else
						pulse_cnt	<= pulse_cnt - 1'b1;
				end

				state_done:	state	<= state_idle;

				default:	state	<= state_idle;

			endcase
		end
	end

	// Capture channel and direction on accept
	always_ff @(posedge clk_250mhz) begin
		if((state == state_idle) && relay_cmd.req) begin
			lat_dir		<= relay_cmd.dir;
			lat_channel	<= relay_cmd.channel;
		end
	end

	//////////////////////////////
	// Coil outputs

	logic[`RELAY_COUNT-1:0]	coil_sel;

	always_comb begin
		coil_sel	= '0;
		if(state == state_pulse)
			coil_sel[lat_channel]	= 1'b1;

		// Direction picks the bridge side
		relay_a		= lat_dir ? coil_sel : '0;
		relay_b		= lat_dir ? '0 : coil_sel;
		relay_done	= (state == state_done);
	end

endmodule

`default_nettype wire

// File: source/trigger_crossbar_top.sv
`default_nettype none

`include "crossbar_config.svh"

module trigger_crossbar_top #(
	parameter int led_hold_cycles		= `LED_HOLD_DEFAULT,
	parameter int relay_pulse_cycles	= `RELAY_PULSE_DEFAULT
)(
	input wire								clk_250mhz,
	input wire								rst,

	// Trigger inputs after the LVDS buffers
	input wire[`TRIG_CHANNELS-1:0]			trig_in,

	// Routing table writes and relay requests
	input wire crossbar_pkg::sel_write_t	sel_wr,
	input wire crossbar_pkg::relay_cmd_t	relay_cmd,

	// Trigger outputs
	output logic[`TRIG_CHANNELS-1:0]		trig_out,

	// Front panel activity LEDs
	output logic[`TRIG_CHANNELS-1:0]		trig_in_led,
	output logic[`TRIG_CHANNELS-1:0]		trig_out_led,

	// Relay H-bridges
	output logic[`RELAY_COUNT-1:0]			relay_a,
	output logic[`RELAY_COUNT-1:0]			relay_b,
	output logic							relay_done
);

	//////////////////////////////
	// Input capture and routing table

	logic[`TRIG_CHANNELS-1:0]						trig_fixed;
	crossbar_pkg::muxsel_t[`TRIG_CHANNELS-1:0]		muxsel;

	trigger_input_stage input_stage(
		.clk_250mhz(clk_250mhz),
		.rst(rst),
		.trig_in(trig_in),
		.trig_fixed(trig_fixed)
	);

	select_register_bank sel_bank(
		.clk_250mhz(clk_250mhz),
		.rst(rst),
		.sel_wr(sel_wr),
		.muxsel(muxsel)
	);

	//////////////////////////////
	// Crossbar

	crossbar_matrix matrix(
		.clk_250mhz(clk_250mhz),
		.rst(rst),
		.trig_fixed(trig_fixed),
		.muxsel(muxsel),
		.trig_out(trig_out)
	);

	//////////////////////////////
	// Activity LEDs

	// Input side watches corrected levels
	activity_stretcher #(
		.width(`TRIG_CHANNELS),
		.led_hold_cycles(led_hold_cycles)
	) in_leds (
		.clk_250mhz(clk_250mhz),
		.rst(rst),
		.activity(trig_fixed),
		.led(trig_in_led)
	);

	activity_stretcher #(
		.width(`TRIG_CHANNELS),
		.led_hold_cycles(led_hold_cycles)
	) out_leds (
		.clk_250mhz(clk_250mhz),
		.rst(rst),
		.activity(trig_out),
		.led(trig_out_led)
	);

	//////////////////////////////
	// Relays

	relay_pulse_driver #(
		.relay_pulse_cycles(relay_pulse_cycles)
	) relays (
		.clk_250mhz(clk_250mhz),
		.rst(rst),
		.relay_cmd(relay_cmd),
		.relay_a(relay_a),
		.relay_b(relay_b),
		.relay_done(relay_done)
	);

endmodule

`default_nettype wire

// File: tests/trigger_crossbar_tb.sv
`default_nettype none

`include "crossbar_config.svh"

module trigger_crossbar_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int led_hold		= 8;
	localparam int relay_pulse	= 6;
	localparam int table_rows	= 6;

	logic								clk_250mhz;
	logic								rst;
	logic[`TRIG_CHANNELS-1:0]			trig_in;
	crossbar_pkg::sel_write_t			sel_wr;
	crossbar_pkg::relay_cmd_t			relay_cmd;
	logic[`TRIG_CHANNELS-1:0]			trig_out;
	logic[`TRIG_CHANNELS-1:0]			trig_in_led;
	logic[`TRIG_CHANNELS-1:0]			trig_out_led;
	logic[`RELAY_COUNT-1:0]				relay_a;
	logic[`RELAY_COUNT-1:0]				relay_b;
	logic								relay_done;

	// Reference copy of the routing table
	logic								model_en[`TRIG_CHANNELS];
	logic[`TRIG_SEL_BITS-1:0]			model_src[`TRIG_CHANNELS];

	// Routing table rows of up to three writes, raw input and expected output
	crossbar_pkg::sel_write_t			row_wr[table_rows][3];
	logic[`TRIG_CHANNELS-1:0]			row_in[table_rows];
	logic[`TRIG_CHANNELS-1:0]			row_exp[table_rows];

	// Inputs swapped on the board for the direct inversion check
	int									masked_src[4] = '{0, 2, 5, 6};
	logic[`TRIG_CHANNELS-1:0]			pattern;

	trigger_crossbar_top #(
		.led_hold_cycles(led_hold),
		.relay_pulse_cycles(relay_pulse)
	) uut (
		.clk_250mhz(clk_250mhz),
		.rst(rst),
		.trig_in(trig_in),
		.sel_wr(sel_wr),
		.relay_cmd(relay_cmd),
		.trig_out(trig_out),
		.trig_in_led(trig_in_led),
		.trig_out_led(trig_out_led),
		.relay_a(relay_a),
		.relay_b(relay_b),
		.relay_done(relay_done)
	);

	always #5 clk_250mhz = ~clk_250mhz;

	//////////////////////////////
	// Reporting

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0d ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0d ns while waiting for %s", $time, what);
		$display("Errors found");
		$fatal(1);
	endtask

	//////////////////////////////
	// Reference model

	function automatic crossbar_pkg::sel_write_t make_write(input int out_idx, input bit en,
		input int src);
		crossbar_pkg::sel_write_t w;
		w.wr_en		= 1'b1;
		w.out_idx	= 4'(out_idx);
		w.sel.en	= en;
		w.sel.src	= 4'(src);
		return w;
	endfunction

	// Undo the board swaps, then route per output
	function automatic logic[`TRIG_CHANNELS-1:0] expected_out(input logic[`TRIG_CHANNELS-1:0] raw);
		logic[`TRIG_CHANNELS-1:0]	fixed;
		logic[`TRIG_CHANNELS-1:0]	result;
		fixed	= raw ^ `TRIG_POLARITY_MASK;
		result	= '0;
		for(int o=0; o<`TRIG_CHANNELS; o++) begin
			if(model_en[o] && (model_src[o] < `TRIG_CHANNELS))
				result[o]	= fixed[model_src[o]];
		end
		return result;
	endfunction

	// One write strobe, one cycle wide
	// Returns at the falling edge after the write edge
	task automatic apply_write(input crossbar_pkg::sel_write_t w);
		sel_wr	= w;
		if(w.wr_en && (w.out_idx < `TRIG_CHANNELS)) begin
			model_en[w.out_idx]		= w.sel.en;
			model_src[w.out_idx]	= w.sel.src;
		end
		@(negedge clk_250mhz);
		sel_wr	= '0;
	endtask

	task automatic check_trig_out(input logic[`TRIG_CHANNELS-1:0] expected, input string what);
		assert(trig_out === expected) else
			report_mismatch($sformatf("%s: trig_out %03h, expected %03h", what, trig_out, expected));
	endtask

	// Drive raw levels and check after the two register stages
	task automatic drive_and_check(input logic[`TRIG_CHANNELS-1:0] raw, input string what);
		trig_in	= raw;
		repeat(2) @(negedge clk_250mhz);
		check_trig_out(expected_out(raw), what);
	endtask

	function automatic logic led_bit(input bit use_out, input int idx);
		return use_out ? trig_out_led[idx] : trig_in_led[idx];
	endfunction

	// Wait for an LED to light, then count how long it stays on
	task automatic check_led_hold(input bit use_out, input int idx);
		int	waited;
		int	lit;
		waited	= 0;
		while(!led_bit(use_out, idx)) begin
			if(waited >= 20)
				report_timeout($sformatf("LED %0d to light", idx));
			waited++;
			@(negedge clk_250mhz);
		end
		lit		= 0;
		while(led_bit(use_out, idx) && (lit <= 20)) begin
			lit++;
			@(negedge clk_250mhz);
		end
		assert(lit == led_hold) else
			report_mismatch($sformatf("LED %0d (out side %0d) lit %0d cycles, expected %0d",
				idx, use_out, lit, led_hold));
	endtask

	// One relay request with an optional conflicting request mid-pulse
	task automatic run_relay(input int ch, input bit dir, input bit poke_mid);
		logic[`RELAY_COUNT-1:0]	coil;
		int						waited;
		int						on;
		coil				= 4'(1 << ch);
		relay_cmd.req		= 1'b1;
		relay_cmd.dir		= dir;
		relay_cmd.channel	= 2'(ch);
		@(negedge clk_250mhz);
		relay_cmd			= '0;
		waited				= 0;
		while((relay_a | relay_b) == 0) begin
			if(waited >= 10)
				report_timeout("relay coil to energize");
			waited++;
			@(negedge clk_250mhz);
		end
		on	= 0;
		while(((relay_a | relay_b) != 0) && (on <= 20)) begin
			assert(dir ? (relay_a == coil && relay_b == 0) : (relay_b == coil && relay_a == 0)) else
				report_mismatch($sformatf("coil drive a=%b b=%b", relay_a, relay_b));
			assert(!relay_done) else
				report_mismatch("relay_done high during pulse");
			if(poke_mid && (on == 2)) begin
				relay_cmd.req		= 1'b1;
				relay_cmd.dir		= ~dir;
				relay_cmd.channel	= 2'(ch + 1);
			end
			else
				relay_cmd			= '0;
			on++;
			@(negedge clk_250mhz);
		end
		assert(on == relay_pulse) else
			report_mismatch($sformatf("coil on for %0d cycles, expected %0d", on, relay_pulse));
		assert(relay_done) else
			report_mismatch("relay_done missing after pulse");
		@(negedge clk_250mhz);
		assert(!relay_done && (relay_a == 0) && (relay_b == 0)) else
			report_mismatch("relay outputs not idle after done strobe");
	endtask

	//////////////////////////////
	// Stimulus table

	task automatic load_table();
		for(int r=0; r<table_rows; r++) begin
			for(int k=0; k<3; k++)
				row_wr[r][k]	= '0;
		end
		// Basic routes, one through a swapped input
		row_wr[0][0] = make_write(0, 1, 3);
		row_wr[0][1] = make_write(1, 1, 0);
		row_in[0] = 12'h008;
		row_exp[0] = 12'h003;
		// Fan-out of input 7
		row_wr[1][0] = make_write(4, 1, 7);
		row_wr[1][1] = make_write(5, 1, 7);
		row_wr[1][2] = make_write(6, 1, 7);
		row_in[1] = 12'h080;
		row_exp[1] = 12'h072;
		// Out of range output indices dropped
		row_wr[2][0] = make_write(12, 1, 11);
		row_wr[2][1] = make_write(15, 1, 5);
		row_wr[2][2] = make_write(2, 1, 11);
		row_in[2] = 12'h801;
		row_exp[2] = 12'h004;
		// Spare source codes give 0
		row_wr[3][0] = make_write(7, 1, 12);
		row_wr[3][1] = make_write(8, 1, 15);
		row_wr[3][2] = make_write(9, 1, 2);
		row_in[3] = 12'hfff;
		row_exp[3] = 12'h075;
		// Disables
		row_wr[4][0] = make_write(4, 0, 7);
		row_wr[4][1] = make_write(5, 0, 0);
		row_wr[4][2] = make_write(10, 1, 5);
		row_in[4] = 12'h000;
		row_exp[4] = 12'h602;
		// Reroutes
		row_wr[5][0] = make_write(0, 1, 6);
		row_wr[5][1] = make_write(11, 1, 0);
		row_wr[5][2] = make_write(3, 1, 9);
		row_in[5] = 12'h240;
		row_exp[5] = 12'he0a;
	endtask

	//////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(103));
		clk_250mhz	= 1'b0;
		rst			= 1'b1;
		trig_in		= '0;
		sel_wr		= '0;
		relay_cmd	= '0;
		for(int o=0; o<`TRIG_CHANNELS; o++) begin
			model_en[o]		= 1'b0;
			model_src[o]	= '0;
		end
		load_table();

		repeat(4) @(posedge clk_250mhz);
		@(negedge clk_250mhz);
		rst	= 1'b0;

		// Reset state
		assert((trig_out == 0) && (trig_in_led == 0) && (trig_out_led == 0)) else
			report_mismatch("trigger outputs or LEDs set after reset");
		assert((relay_a == 0) && (relay_b == 0) && !relay_done) else
			report_mismatch("relay outputs set after reset");
		trig_in	= 12'hfff;
		repeat(4) begin
			@(negedge clk_250mhz);
			check_trig_out('0, "all selects disabled");
		end

		for(int r=0; r<table_rows; r++) begin
			for(int k=0; k<3; k++)
				apply_write(row_wr[r][k]);
			trig_in	= row_in[r];
			repeat(2) @(negedge clk_250mhz);
			check_trig_out(row_exp[r], $sformatf("table row %0d", r));
		end

		// Swapped inputs come out inverted
		for(int o=0; o<4; o++)
			apply_write(make_write(o, 1, masked_src[o]));
		for(int p=0; p<3; p++) begin
			pattern	= (p == 0) ? 12'h000 : ((p == 1) ? 12'hfff : 12'h0a5);
			trig_in	= pattern;
			repeat(2) @(negedge clk_250mhz);
			for(int o=0; o<4; o++) begin
				assert(trig_out[o] === ~pattern[masked_src[o]]) else
					report_mismatch($sformatf("output %0d not inverted for raw %03h", o, pattern));
			end
		end
		for(int n=0; n<50; n++)
			drive_and_check(12'($urandom), $sformatf("random pattern %0d", n));

		// Select changes land exactly one cycle after the write edge
		drive_and_check(12'h000, "before select change");
		for(int n=0; n<2; n++) begin
			pattern	= expected_out(trig_in);
			apply_write((n == 0) ? make_write(1, 0, 2) : make_write(9, 1, 3));
			check_trig_out(pattern, "old routing at write edge");
			@(negedge clk_250mhz);
			check_trig_out(expected_out(trig_in), "new routing one cycle after write");
		end

		// LED stretch on input 3 routed to output 11
		apply_write(make_write(11, 1, 3));
		trig_in	= `TRIG_POLARITY_MASK;
		repeat(12) @(negedge clk_250mhz);
		trig_in	= `TRIG_POLARITY_MASK | 12'h008;
		fork
			begin
				@(negedge clk_250mhz);
				trig_in	= `TRIG_POLARITY_MASK;
			end
			check_led_hold(1'b0, 3);
			check_led_hold(1'b1, 11);
		join

		// Relay pulses with a request dropped while busy
		run_relay(2, 1'b1, 1'b1);
		repeat(4) begin
			@(negedge clk_250mhz);
			assert((relay_a == 0) && (relay_b == 0) && !relay_done) else
				report_mismatch("request issued while busy was accepted");
		end
		run_relay(1, 1'b0, 1'b0);

		repeat(2) @(negedge clk_250mhz);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: trigger_crossbar_top.f
+incdir+source
source/crossbar_pkg.sv
source/trigger_input_stage.sv
source/select_register_bank.sv
source/crossbar_matrix.sv
source/activity_stretcher.sv
source/relay_pulse_driver.sv
source/trigger_crossbar_top.sv
tests/trigger_crossbar_tb.sv

// File: Makefile
# Verilator build for the trigger crossbar testbench

TOP = trigger_crossbar_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): trigger_crossbar_top.f source/*.sv source/*.svh tests/*.sv
	verilator --binary --timing --assert -f trigger_crossbar_top.f --top-module $(TOP) -o V$(TOP)

# Exit status of the binary is the pass or fail result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
